// File: source/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath and pc width
`define XLEN        32

// architectural register file
`define REG_ADDR_W  5
`define NUM_REGS    32

// instruction memory, word addressed
`define IMEM_DEPTH  64
`define IMEM_ADDR_W 6

// byte step per instruction
`define PC_STEP     4

// all-zero word halts fetch
`define STOP_WORD   32'h0000_0000

`endif

// File: source/cpu_pkg.sv
package cpu_pkg;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_t;

    // alu operations, low values follow funct3 ordering
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SLL    = 4'd1,
        ALU_SLT    = 4'd2,
        ALU_SLTU   = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SRL    = 4'd5,
        ALU_OR     = 4'd6,
        ALU_AND    = 4'd7,
        ALU_SUB    = 4'd8,
        ALU_SRA    = 4'd13,
        // lui, result is operand b
        ALU_PASS_B = 4'd15
    } alu_op_t;

endpackage

// File: source/instr_fetch.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module instr_fetch (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    run,
    input  logic                    imem_we,
    input  logic [`IMEM_ADDR_W-1:0] imem_addr,
    input  logic [`XLEN-1:0]        imem_wdata,
    output logic                    fetch_valid,
    output logic [`XLEN-1:0]        fetch_pc,
    output logic [`XLEN-1:0]        fetch_instr,
    output logic                    halted
);

    logic [`XLEN-1:0] imem [`IMEM_DEPTH];
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] cur_word;
    logic             fetch_en;
    logic             is_stop;

    assign fetch_en = run && !halted;

    // word index from the byte pc
    assign cur_word = imem[pc[`IMEM_ADDR_W+1:2]];
    assign is_stop  = (cur_word == `STOP_WORD);

    // program load, only while the core is idle
    always_ff @(posedge clk) begin
        if (imem_we && !run) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc          <= '0;
            fetch_valid <= 1'b0;
            halted      <= 1'b0;
        end else begin
            fetch_valid <= fetch_en && !is_stop;
            if (fetch_en) begin
                if (is_stop) begin
                    // sticky until reset
                    halted <= 1'b1;
                end else begin
                    pc <= pc + `XLEN'(`PC_STEP);
                end
            end
        end
    end

    // fetch-to-decode payload
    always_ff @(posedge clk) begin
        if (fetch_en) begin
            fetch_pc    <= pc;
            fetch_instr <= cur_word;
        end
    end

    a_no_load_while_run: assert property (
        @(posedge clk) disable iff (!rstn)
        !(imem_we && run)
    ) else $error("imem write while run is high");

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    output logic [`XLEN-1:0]       rd1,
    output logic [`XLEN-1:0]       rd2,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] wa,
    input  logic [`XLEN-1:0]       wd
);

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic             wr_ok;

    // x0 is never written
    assign wr_ok = we && (wa != '0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wa] <= wd;
        end
    end

    // write-through for a same-cycle write
    always_comb begin
        if (rs1 == '0) begin
            rd1 = '0;
        end else if (wr_ok && (wa == rs1)) begin
            rd1 = wd;
        end else begin
            rd1 = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == '0) begin
            rd2 = '0;
        end else if (wr_ok && (wa == rs2)) begin
            rd2 = wd;
        end else begin
            rd2 = regs[rs2];
        end
    end

endmodule

// File: source/instr_decode.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module instr_decode (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   fetch_valid,
    input  logic [`XLEN-1:0]       fetch_pc,
    input  logic [`XLEN-1:0]       fetch_instr,
    input  logic                   wb_en,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    input  logic [`XLEN-1:0]       wb_data,
    output logic                   dec_valid,
    output logic [`XLEN-1:0]       dec_pc,
    output cpu_pkg::alu_op_t       dec_op,
    output logic [`REG_ADDR_W-1:0] dec_rd,
    output logic [`REG_ADDR_W-1:0] dec_rs1,
    output logic [`REG_ADDR_W-1:0] dec_rs2,
    output logic [`XLEN-1:0]       dec_a,
    output logic [`XLEN-1:0]       dec_b
);

    cpu_pkg::opcode_t       opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rd_f;
    logic [`REG_ADDR_W-1:0] rs1_f;
    logic [`REG_ADDR_W-1:0] rs2_f;
    logic [`XLEN-1:0]       imm_i;
    logic [`XLEN-1:0]       imm_u;

    logic                   legal;
    logic                   use_imm;
    cpu_pkg::alu_op_t       alu_op;
    logic [`REG_ADDR_W-1:0] src1;
    logic [`REG_ADDR_W-1:0] src2;
    logic [`XLEN-1:0]       imm;
    logic [`XLEN-1:0]       rd1;
    logic [`XLEN-1:0]       rd2;

    // funct3 picks the op, alt selects sub or sra
    function automatic cpu_pkg::alu_op_t op_from_funct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
            3'b001:  return cpu_pkg::ALU_SLL;
            3'b010:  return cpu_pkg::ALU_SLT;
            3'b011:  return cpu_pkg::ALU_SLTU;
            3'b100:  return cpu_pkg::ALU_XOR;
            3'b101:  return alt ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
            3'b110:  return cpu_pkg::ALU_OR;
            default: return cpu_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode = cpu_pkg::opcode_t'(fetch_instr[6:0]);
    assign rd_f   = fetch_instr[11:7];
    assign funct3 = fetch_instr[14:12];
    assign rs1_f  = fetch_instr[19:15];
    assign rs2_f  = fetch_instr[24:20];
    assign funct7 = fetch_instr[31:25];

    assign imm_i = {{20{fetch_instr[31]}}, fetch_instr[31:20]};
    assign imm_u = {fetch_instr[31:12], 12'b0};

    always_comb begin
        legal   = 1'b0;
        use_imm = 1'b0;
        alu_op  = cpu_pkg::ALU_ADD;
        src1    = rs1_f;
        src2    = rs2_f;
        imm     = imm_i;
        case (opcode)
            cpu_pkg::OPC_OP: begin
                legal  = (funct7 == 7'h00) ||
                         ((funct7 == 7'h20) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
                alu_op = op_from_funct(funct3, funct7[5]);
            end
            cpu_pkg::OPC_OP_IMM: begin
                use_imm = 1'b1;
                src2    = '0;
                // shifts keep funct7 in the upper immediate bits
                case (funct3)
                    3'b001:  legal = (funct7 == 7'h00);
                    3'b101:  legal = (funct7 == 7'h00) || (funct7 == 7'h20);
                    default: legal = 1'b1;
                endcase
                alu_op = op_from_funct(funct3, (funct3 == 3'b101) && funct7[5]);
            end
            cpu_pkg::OPC_LUI: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                src1    = '0;
                src2    = '0;
                imm     = imm_u;
                alu_op  = cpu_pkg::ALU_PASS_B;
            end
            default: ;
        endcase
    end

    reg_file reg_file_inst (
        .clk  (clk),
        .rstn (rstn),
        .rs1  (src1),
        .rs2  (src2),
        .rd1  (rd1),
        .rd2  (rd2),
        .we   (wb_en),
        .wa   (wb_rd),
        .wd   (wb_data)
    );

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= fetch_valid && legal;
        end
    end

    // decode-to-execute payload
    always_ff @(posedge clk) begin
        dec_pc  <= fetch_pc;
        dec_op  <= alu_op;
        dec_rd  <= rd_f;
        dec_rs1 <= src1;
        dec_rs2 <= src2;
        dec_a   <= rd1;
        dec_b   <= use_imm ? imm : rd2;
    end

endmodule

// File: source/execute_retire.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module execute_retire (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   dec_valid,
    input  logic [`XLEN-1:0]       dec_pc,
    input  cpu_pkg::alu_op_t       dec_op,
    input  logic [`REG_ADDR_W-1:0] dec_rd,
    input  logic [`REG_ADDR_W-1:0] dec_rs1,
    input  logic [`REG_ADDR_W-1:0] dec_rs2,
    input  logic [`XLEN-1:0]       dec_a,
    input  logic [`XLEN-1:0]       dec_b,
    output logic                   retire_valid,
    output logic [`XLEN-1:0]       retire_pc,
    output logic [`REG_ADDR_W-1:0] retire_rd,
    output logic [`XLEN-1:0]       retire_data
);

    localparam int SHAMT_W = $clog2(`XLEN);

    logic               fwd_a;
    logic               fwd_b;
    logic [`XLEN-1:0]   op_a;
    logic [`XLEN-1:0]   op_b;
    logic [SHAMT_W-1:0] shamt;
    logic [`XLEN-1:0]   alu_result;

    // distance-one hazard, take the result still in the retire register
    assign fwd_a = retire_valid && (retire_rd != '0) && (retire_rd == dec_rs1);
    assign fwd_b = retire_valid && (retire_rd != '0) && (retire_rd == dec_rs2);

    assign op_a  = fwd_a ? retire_data : dec_a;
    assign op_b  = fwd_b ? retire_data : dec_b;
    assign shamt = op_b[SHAMT_W-1:0];

    always_comb begin
        case (dec_op)
            cpu_pkg::ALU_ADD:    alu_result = op_a + op_b;
            cpu_pkg::ALU_SUB:    alu_result = op_a - op_b;
            cpu_pkg::ALU_AND:    alu_result = op_a & op_b;
            cpu_pkg::ALU_OR:     alu_result = op_a | op_b;
            cpu_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
            cpu_pkg::ALU_SLL:    alu_result = op_a << shamt;
            cpu_pkg::ALU_SRL:    alu_result = op_a >> shamt;
            cpu_pkg::ALU_SRA:    alu_result = $signed(op_a) >>> shamt;
            cpu_pkg::ALU_SLT:    alu_result = `XLEN'($signed(op_a) < $signed(op_b));
            cpu_pkg::ALU_SLTU:   alu_result = `XLEN'(op_a < op_b);
            cpu_pkg::ALU_PASS_B: alu_result = op_b;
            default:             alu_result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= dec_valid;
        end
    end

    // retire payload, also the register file write port
    always_ff @(posedge clk) begin
        retire_pc   <= dec_pc;
        retire_rd   <= dec_rd;
        retire_data <= alu_result;
    end

    a_retire_known: assert property (
        @(posedge clk) disable iff (!rstn)
        !$isunknown(retire_valid)
    ) else $error("retire_valid unknown after reset");

endmodule

// File: source/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    run,
    input  logic                    imem_we,
    input  logic [`IMEM_ADDR_W-1:0] imem_addr,
    input  logic [`XLEN-1:0]        imem_wdata,
    output logic                    retire_valid,
    output logic [`XLEN-1:0]        retire_pc,
    output logic [`REG_ADDR_W-1:0]  retire_rd,
    output logic [`XLEN-1:0]        retire_data,
    output logic                    halted
);

    logic                   fetch_valid;
    logic [`XLEN-1:0]       fetch_pc;
    logic [`XLEN-1:0]       fetch_instr;

    logic                   dec_valid;
    logic [`XLEN-1:0]       dec_pc;
    cpu_pkg::alu_op_t       dec_op;
    logic [`REG_ADDR_W-1:0] dec_rd;
    logic [`REG_ADDR_W-1:0] dec_rs1;
    logic [`REG_ADDR_W-1:0] dec_rs2;
    logic [`XLEN-1:0]       dec_a;
    logic [`XLEN-1:0]       dec_b;

    instr_fetch instr_fetch_inst (
        .clk         (clk),
        .rstn        (rstn),
        .run         (run),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .halted      (halted)
    );

    // retire outputs loop back as the writeback port
    instr_decode instr_decode_inst (
        .clk         (clk),
        .rstn        (rstn),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .wb_en       (retire_valid),
        .wb_rd       (retire_rd),
        .wb_data     (retire_data),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_op      (dec_op),
        .dec_rd      (dec_rd),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_a       (dec_a),
        .dec_b       (dec_b)
    );

    execute_retire execute_retire_inst (
        .clk          (clk),
        .rstn         (rstn),
        .dec_valid    (dec_valid),
        .dec_pc       (dec_pc),
        .dec_op       (dec_op),
        .dec_rd       (dec_rd),
        .dec_rs1      (dec_rs1),
        .dec_rs2      (dec_rs2),
        .dec_a        (dec_a),
        .dec_b        (dec_b),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

// File: tests/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_tb;

    typedef enum int {
        T_ADD, T_SUB, T_AND, T_OR, T_XOR, T_SLL, T_SRL, T_SRA, T_SLT, T_SLTU,
        T_ADDI, T_ANDI, T_ORI, T_XORI, T_SLTI, T_SLTIU, T_SLLI, T_SRLI, T_SRAI,
        T_LUI
    } tb_op_e;

    localparam int MAX_ROWS = 40;

    logic                    clk;
    logic                    rstn;
    logic                    run;
    logic                    imem_we;
    logic [`IMEM_ADDR_W-1:0] imem_addr;
    logic [`XLEN-1:0]        imem_wdata;
    logic                    retire_valid;
    logic [`XLEN-1:0]        retire_pc;
    logic [`REG_ADDR_W-1:0]  retire_rd;
    logic [`XLEN-1:0]        retire_data;
    logic                    halted;

    tb_op_e      row_op   [MAX_ROWS];
    logic [4:0]  row_rd   [MAX_ROWS];
    logic [4:0]  row_rs1  [MAX_ROWS];
    logic [4:0]  row_rs2  [MAX_ROWS];
    logic [31:0] row_imm  [MAX_ROWS];
    logic [31:0] exp_pc   [MAX_ROWS];
    logic [4:0]  exp_rd   [MAX_ROWS];
    logic [31:0] exp_data [MAX_ROWS];
    int          n_rows;
    logic [15:0] lfsr_state;
    int          mismatch_errors;
    int          other_errors;

    cpu_top cpu_top_inst (
        .clk          (clk),
        .rstn         (rstn),
        .run          (run),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_imm12();
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < 12; k++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    task automatic add_row(input tb_op_e op, input int rd, input int rs1, input int rs2,
                           input int imm, input bit rnd);
        row_op[n_rows]  = op;
        row_rd[n_rows]  = rd[4:0];
        row_rs1[n_rows] = rs1[4:0];
        row_rs2[n_rows] = rs2[4:0];
        row_imm[n_rows] = rnd ? random_imm12() : imm;
        n_rows++;
    endtask

    function automatic logic [31:0] encode(input tb_op_e op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [31:0] imm);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = 7'h00;
        case (op)
            T_SUB: begin
                f3 = 3'd0;
                f7 = 7'h20;
            end
            T_SLL, T_SLLI:     f3 = 3'd1;
            T_SLT, T_SLTI:     f3 = 3'd2;
            T_SLTU, T_SLTIU:   f3 = 3'd3;
            T_XOR, T_XORI:     f3 = 3'd4;
            T_SRL, T_SRLI:     f3 = 3'd5;
            T_SRA, T_SRAI: begin
                f3 = 3'd5;
                f7 = 7'h20;
            end
            T_OR, T_ORI:       f3 = 3'd6;
            T_AND, T_ANDI:     f3 = 3'd7;
            default:           f3 = 3'd0;
        endcase
        if (op == T_LUI) begin
            return {imm[19:0], rd, cpu_pkg::OPC_LUI};
        end else if (op <= T_SLTU) begin
            return {f7, rs2, rs1, f3, rd, cpu_pkg::OPC_OP};
        end else if (op == T_SLLI || op == T_SRLI || op == T_SRAI) begin
            return {f7, imm[4:0], rs1, f3, rd, cpu_pkg::OPC_OP_IMM};
        end
        return {imm[11:0], rs1, f3, rd, cpu_pkg::OPC_OP_IMM};
    endfunction

    // architectural result of one instruction
    function automatic logic [31:0] model_alu(input tb_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            T_ADD, T_ADDI:   return a + b;
            T_SUB:           return a - b;
            T_AND, T_ANDI:   return a & b;
            T_OR, T_ORI:     return a | b;
            T_XOR, T_XORI:   return a ^ b;
            T_SLL, T_SLLI:   return a << b[4:0];
            T_SRL, T_SRLI:   return a >> b[4:0];
            T_SRA, T_SRAI:   return $signed(a) >>> b[4:0];
            T_SLT, T_SLTI:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            T_SLTU, T_SLTIU: return (a < b) ? 32'd1 : 32'd0;
            default:         return b;
        endcase
    endfunction

    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] b;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int i = 0; i < n_rows; i++) begin
            if (row_op[i] <= T_SLTU) begin
                b = regs[row_rs2[i]];
            end else if (row_op[i] == T_LUI) begin
                b = {row_imm[i][19:0], 12'h000};
            end else begin
                b = {{20{row_imm[i][11]}}, row_imm[i][11:0]};
            end
            exp_pc[i]   = i * `PC_STEP;
            exp_rd[i]   = row_rd[i];
            exp_data[i] = model_alu(row_op[i], (row_op[i] == T_LUI) ? 32'h0 : regs[row_rs1[i]], b);
            if (row_rd[i] != 5'd0) begin
                regs[row_rd[i]] = exp_data[i];
            end
        end
    endtask

    task automatic check_field(input string name, input int row, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatch_errors++;
            $display("MISMATCH %s row %0d: got 0x%08h expected 0x%08h", name, row, got, exp);
        end
    endtask

    initial begin
        int          ret_count;
        int          wait_cnt;
        logic [31:0] word;
        rstn            = 1'b0;
        run             = 1'b0;
        imem_we         = 1'b0;
        imem_addr       = '0;
        imem_wdata      = '0;
        n_rows          = 0;
        lfsr_state      = 16'd34;
        mismatch_errors = 0;
        other_errors    = 0;

        add_row(T_ADDI, 1, 0, 0, 5, 0);
        add_row(T_ADDI, 2, 0, 0, 12'hffd, 0);
        add_row(T_SUB, 3, 1, 2, 0, 0);
        // underflow followed by negative shifts and mixed-sign compares
        add_row(T_SUB, 4, 0, 1, 0, 0);
        add_row(T_SRA, 5, 4, 1, 0, 0);
        add_row(T_SRL, 6, 4, 1, 0, 0);
        add_row(T_SLT, 7, 4, 1, 0, 0);
        add_row(T_SLTU, 8, 4, 1, 0, 0);
        add_row(T_SLL, 9, 1, 1, 0, 0);
        add_row(T_AND, 10, 4, 2, 0, 0);
        add_row(T_OR, 11, 1, 2, 0, 0);
        add_row(T_XOR, 12, 4, 2, 0, 0);
        add_row(T_ADD, 13, 12, 11, 0, 0);
        add_row(T_LUI, 14, 0, 0, 20'h80001, 0);
        add_row(T_SRAI, 15, 14, 0, 4, 0);
        add_row(T_SRLI, 16, 14, 0, 8, 0);
        add_row(T_SLLI, 17, 1, 0, 31, 0);
        add_row(T_ADDI, 18, 14, 0, 0, 1);
        add_row(T_ANDI, 19, 18, 0, 0, 1);
        add_row(T_ORI, 20, 19, 0, 0, 1);
        add_row(T_XORI, 21, 20, 0, 0, 1);
        add_row(T_SLTI, 22, 4, 0, 0, 1);
        add_row(T_SLTIU, 23, 4, 0, 0, 1);
        // x0 written and then read at distance one and two
        add_row(T_ADDI, 0, 1, 0, 7, 0);
        add_row(T_ADD, 24, 0, 1, 0, 0);
        add_row(T_OR, 25, 0, 0, 0, 0);
        add_row(T_SUB, 26, 24, 25, 0, 0);
        run_model();

        repeat (10) @(posedge clk);
        rstn <= 1'b1;

        for (int i = 0; i <= n_rows; i++) begin
            word = (i < n_rows) ? encode(row_op[i], row_rd[i], row_rs1[i], row_rs2[i],
                                         row_imm[i]) : `STOP_WORD;
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= `IMEM_ADDR_W'(i);
            imem_wdata <= word;
            @(negedge clk);
            check_field("retire_valid", i, 32'(retire_valid), 32'h0);
            check_field("halted", i, 32'(halted), 32'h0);
        end
        @(posedge clk);
        imem_we <= 1'b0;
        @(posedge clk);
        run <= 1'b1;

        ret_count = 0;
        wait_cnt  = 0;
        while (ret_count < n_rows && wait_cnt < 100) begin
            @(negedge clk);
            if (retire_valid === 1'b1) begin
                check_field("retire_pc", ret_count, retire_pc, exp_pc[ret_count]);
                check_field("retire_rd", ret_count, 32'(retire_rd), 32'(exp_rd[ret_count]));
                check_field("retire_data", ret_count, retire_data, exp_data[ret_count]);
                ret_count++;
                wait_cnt = 0;
            end else begin
                wait_cnt++;
            end
        end
        if (ret_count < n_rows) begin
            other_errors++;
            $display("timeout: only %0d of %0d instructions retired", ret_count, n_rows);
        end

        // nothing more may retire in the drain window
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            if (retire_valid === 1'b1) begin
                other_errors++;
                $display("extra retire seen after the last expected instruction");
            end
        end
        check_field("halted", n_rows, 32'(halted), 32'h1);

        $display("errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+source
source/cpu_pkg.sv
source/instr_fetch.sv
source/reg_file.sv
source/instr_decode.sv
source/execute_retire.sv
source/cpu_top.sv
tests/cpu_tb.sv
